// File: common/trace_cpu_config.svh
`ifndef TRACE_CPU_CONFIG_SVH
`define TRACE_CPU_CONFIG_SVH

////////////////////
// datapath widths

// data and instruction word
`define TC_WORD_W       16
// both memories, and the pc
`define TC_ADDR_W       6
// register index, eight registers
`define TC_REG_W        3

////////////////////
// trace sizing

// instruction id, wraps
`define TC_ID_W         8
// record table entries, at least five in flight
`define TC_TRACE_DEPTH  8
// free running cycle count
`define TC_CYCLE_W      16

`endif

// File: common/trace_cpu_pkg.sv
`include "trace_cpu_config.svh"

package trace_cpu_pkg;

    ////////////////////
    // datapath types

    typedef logic [`TC_WORD_W-1:0]  word_t;
    typedef logic [`TC_ADDR_W-1:0]  addr_t;
    typedef logic [`TC_REG_W-1:0]   reg_idx_t;

    ////////////////////
    // trace types

    typedef logic [`TC_ID_W-1:0]    id_t;
    typedef logic [`TC_CYCLE_W-1:0] cycle_t;

    ////////////////////
    // opcodes

    // top nibble of the instruction word
    // rd [11:9], rs [8:6], rt [5:3] or signed imm [5:0]
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_ADDI = 4'd3,
        OP_LD   = 4'd4,
        OP_ST   = 4'd5,
        OP_BEQZ = 4'd6,
        OP_HALT = 4'd7
    } opcode_e;

endpackage

// File: common/stage_if.sv
interface stage_if;
    import trace_cpu_pkg::*;

    // slot state
    logic     valid;
    logic     flushed;
    id_t      id;
    // instruction as fetched
    addr_t    pc;
    word_t    instr;
    // decoded fields and operands
    opcode_e  op;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    result;
    logic     we;

    // stage that loads the register
    modport src (output valid, flushed, id, pc, instr, op, rd, a, b, result, we);

    // next stage down
    modport dst (input valid, flushed, id, pc, instr, op, rd, a, b, result, we);

    // observers, control and trace
    modport mon (input valid, flushed, id, pc, instr, op, rd, a, b, result, we);

endinterface

// File: pipeline/pipe_ctrl.sv
module pipe_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic run,
    stage_if.mon if_id,
    stage_if.mon id_ex,
    stage_if.mon ex_mem,
    stage_if.mon mem_wb,
    input  logic branch_taken,
    output logic fetch_en,
    output logic stall,
    output logic flush,
    output logic halted
);
    import trace_cpu_pkg::*;

    reg_idx_t src_a;
    reg_idx_t src_b;
    logic     use_a;
    logic     use_b;
    logic     hazard;
    logic     halt_in_dec;
    logic     halt_seen;

    // does a pending writer hit either source of the decode slot
    function automatic logic clash(input logic wr, input reg_idx_t dst);
        return wr && ((use_a && dst == src_a) || (use_b && dst == src_b));
    endfunction

    ////////////////////
    // source registers

    always_comb begin
        src_a = if_id.instr[8:6];
        // store data comes from rd
        src_b = (if_id.op == OP_ST) ? if_id.rd : if_id.instr[5:3];
        use_a = 1'b0;
        use_b = 1'b0;
        case (if_id.op)
            OP_ADD, OP_SUB, OP_ST: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            OP_ADDI, OP_LD, OP_BEQZ: use_a = 1'b1;
            default: ;
        endcase
    end

    ////////////////////
    // hazard and flush

    // no forwarding, writeback is covered by the write-through file
    assign hazard = if_id.valid && !if_id.flushed &&
                    (clash(id_ex.valid && !id_ex.flushed && id_ex.we, id_ex.rd) ||
                     clash(ex_mem.valid && !ex_mem.flushed && ex_mem.we, ex_mem.rd));

    // taken branch already qualified in execute
    assign flush = branch_taken;
    // flush wins
    assign stall = hazard && !flush;

    ////////////////////
    // fetch enable, halt

    // halt in decode, unless it is about to be flushed
    assign halt_in_dec = if_id.valid && !if_id.flushed && (if_id.op == OP_HALT) && !flush;
    assign fetch_en    = run && !halt_seen && !halt_in_dec && !halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_seen <= 1'b0;
            halted    <= 1'b0;
        end else begin
            if (halt_in_dec) begin
                halt_seen <= 1'b1;
            end
            // sticky once the halt retires
            if (mem_wb.valid && !mem_wb.flushed && mem_wb.op == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: pipeline/fetch_stage.sv
`include "trace_cpu_config.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_en,
    input  logic                 stall,
    input  logic                 flush,
    input  trace_cpu_pkg::addr_t branch_target,
    input  trace_cpu_pkg::id_t   fetch_id,
    input  logic                 imem_we,
    input  trace_cpu_pkg::addr_t imem_addr,
    input  trace_cpu_pkg::word_t imem_wdata,
    stage_if.src                 if_id
);
    import trace_cpu_pkg::*;

    word_t imem [2**`TC_ADDR_W];
    addr_t pc;
    logic  take;

    // fetch goes ahead on flush, the new entry just arrives dead
    assign take = fetch_en && (flush || !stall);

    // load port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    ////////////////////
    // program counter

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branch_target;
        end else if (take) begin
            pc <= pc + addr_t'(1);
        end
    end

    ////////////////////
    // if_id register

    // held while stalled, emptied when fetch is off
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id.valid   <= 1'b0;
            if_id.flushed <= 1'b0;
        end else if (flush || !stall) begin
            if_id.valid   <= take;
            if_id.flushed <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if_id.id    <= fetch_id;
            if_id.pc    <= pc;
            if_id.instr <= imem[pc];
        end
    end

    // predecode for control
    assign if_id.op     = opcode_e'(if_id.instr[15:12]);
    assign if_id.rd     = if_id.instr[11:9];
    // operands come later
    assign if_id.a      = '0;
    assign if_id.b      = '0;
    assign if_id.result = '0;
    assign if_id.we     = 1'b0;

endmodule

// File: pipeline/decode_stage.sv
module decode_stage (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    stage_if.dst if_id,
    stage_if.dst mem_wb,
    stage_if.src id_ex
);
    import trace_cpu_pkg::*;

    word_t    regs [8];
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_val;
    word_t    b_val;
    logic     wb_en;
    logic     writes;

    // r0 reads zero, writeback value seen in the same cycle
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && mem_wb.rd == idx) begin
            return mem_wb.result;
        end
        return regs[idx];
    endfunction

    ////////////////////
    // field decode

    assign rs = if_id.instr[8:6];
    assign rt = if_id.instr[5:3];

    always_comb begin
        rs_val = read_reg(rs);
        // ST carries rd as store data
        b_val  = (if_id.op == OP_ST) ? read_reg(if_id.rd) : read_reg(rt);
        case (if_id.op)
            OP_ADD, OP_SUB, OP_ADDI, OP_LD: writes = (if_id.rd != '0);
            default: writes = 1'b0;
        endcase
    end

    ////////////////////
    // register file

    assign wb_en = mem_wb.valid && !mem_wb.flushed && mem_wb.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && mem_wb.rd != '0) begin
            regs[mem_wb.rd] <= mem_wb.result;
        end
    end

    ////////////////////
    // id_ex register

    // flush marks the entry, stall drops a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid   <= 1'b0;
            id_ex.flushed <= 1'b0;
        end else if (flush) begin
            id_ex.valid   <= if_id.valid;
            id_ex.flushed <= 1'b1;
        end else if (stall) begin
            id_ex.valid   <= 1'b0;
            id_ex.flushed <= 1'b0;
        end else begin
            id_ex.valid   <= if_id.valid;
            id_ex.flushed <= if_id.flushed;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.id     <= if_id.id;
        id_ex.pc     <= if_id.pc;
        id_ex.instr  <= if_id.instr;
        id_ex.op     <= opcode_e'(if_id.instr[15:12]);
        id_ex.rd     <= if_id.instr[11:9];
        id_ex.a      <= rs_val;
        id_ex.b      <= b_val;
        id_ex.result <= '0;
        // flushed entries never write
        id_ex.we     <= writes && !if_id.flushed && !flush;
    end

endmodule

// File: pipeline/execute_stage.sv
`include "trace_cpu_config.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    stage_if.dst                  id_ex,
    stage_if.src                  ex_mem,
    output logic                  branch_taken,
    output trace_cpu_pkg::addr_t  branch_target
);
    import trace_cpu_pkg::*;

    word_t imm;
    word_t alu;

    // signed 6 bit immediate
    assign imm = {{(`TC_WORD_W-6){id_ex.instr[5]}}, id_ex.instr[5:0]};

    ////////////////////
    // alu

    always_comb begin
        case (id_ex.op)
            OP_ADD:               alu = id_ex.a + id_ex.b;
            OP_SUB:               alu = id_ex.a - id_ex.b;
            // ADDI sum, LD/ST address
            OP_ADDI, OP_LD, OP_ST: alu = id_ex.a + imm;
            default:              alu = '0;
        endcase
    end

    ////////////////////
    // branch resolve

    // only live branches count
    assign branch_taken  = id_ex.valid && !id_ex.flushed &&
                           (id_ex.op == OP_BEQZ) && (id_ex.a == '0);
    // offset wraps with the 6 bit pc
    assign branch_target = id_ex.pc + addr_t'(1) + addr_t'(id_ex.instr[5:0]);

    ////////////////////
    // ex_mem register

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid   <= 1'b0;
            ex_mem.flushed <= 1'b0;
        end else begin
            ex_mem.valid   <= id_ex.valid;
            ex_mem.flushed <= id_ex.flushed;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.id     <= id_ex.id;
        ex_mem.pc     <= id_ex.pc;
        ex_mem.instr  <= id_ex.instr;
        ex_mem.op     <= id_ex.op;
        ex_mem.rd     <= id_ex.rd;
        ex_mem.a      <= id_ex.a;
        // store data rides along in b
        ex_mem.b      <= id_ex.b;
        ex_mem.result <= alu;
        ex_mem.we     <= id_ex.we;
    end

endmodule

// File: pipeline/mem_stage.sv
`include "trace_cpu_config.svh"

module mem_stage (
    input  logic clk,
    input  logic rst,
    stage_if.dst ex_mem,
    stage_if.src mem_wb
);
    import trace_cpu_pkg::*;

    word_t dmem [2**`TC_ADDR_W];
    addr_t daddr;
    logic  st_en;

    // address from the alu result
    assign daddr = ex_mem.result[`TC_ADDR_W-1:0];
    // flushed stores are dropped
    assign st_en = ex_mem.valid && !ex_mem.flushed && (ex_mem.op == OP_ST);

    ////////////////////
    // data memory

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`TC_ADDR_W; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_en) begin
            dmem[daddr] <= ex_mem.b;
        end
    end

    ////////////////////
    // mem_wb register

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid   <= 1'b0;
            mem_wb.flushed <= 1'b0;
        end else begin
            mem_wb.valid   <= ex_mem.valid;
            mem_wb.flushed <= ex_mem.flushed;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb.id     <= ex_mem.id;
        mem_wb.pc     <= ex_mem.pc;
        mem_wb.instr  <= ex_mem.instr;
        mem_wb.op     <= ex_mem.op;
        mem_wb.rd     <= ex_mem.rd;
        mem_wb.a      <= ex_mem.a;
        mem_wb.b      <= ex_mem.b;
        // load data replaces the address
        mem_wb.result <= (ex_mem.op == OP_LD) ? dmem[daddr] : ex_mem.result;
        mem_wb.we     <= ex_mem.we;
    end

endmodule

// File: trace/trace_unit.sv
`include "trace_cpu_config.svh"

module trace_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_en,
    input  logic                  stall,
    stage_if.mon                  if_id,
    stage_if.mon                  id_ex,
    stage_if.mon                  ex_mem,
    stage_if.mon                  mem_wb,
    output trace_cpu_pkg::id_t    fetch_id,
    output logic                  retire_valid,
    output trace_cpu_pkg::id_t    retire_id,
    output trace_cpu_pkg::addr_t  retire_pc,
    output trace_cpu_pkg::word_t  retire_instr,
    output trace_cpu_pkg::word_t  retire_result,
    output logic                  retire_flushed,
    output trace_cpu_pkg::cycle_t retire_cycle
);
    import trace_cpu_pkg::*;

    localparam int IDX_W = $clog2(`TC_TRACE_DEPTH);
    typedef logic [IDX_W-1:0] idx_t;

    addr_t  pc_tab     [`TC_TRACE_DEPTH];
    word_t  instr_tab  [`TC_TRACE_DEPTH];
    word_t  result_tab [`TC_TRACE_DEPTH];
    cycle_t cycle;
    idx_t   wb_idx;

    // table slot for an id
    function automatic idx_t slot(input id_t id);
        return idx_t'(id % `TC_TRACE_DEPTH);
    endfunction

    ////////////////////
    // numbering, cycles

    // stall already yields to flush
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_id <= '0;
            cycle    <= '0;
        end else begin
            cycle <= cycle + cycle_t'(1);
            if (fetch_en && !stall) begin
                fetch_id <= fetch_id + id_t'(1);
            end
        end
    end

    ////////////////////
    // record table

    // each stage fills in its part as the id passes
    always_ff @(posedge clk) begin
        if (if_id.valid) begin
            pc_tab[slot(if_id.id)] <= if_id.pc;
        end
        if (id_ex.valid) begin
            instr_tab[slot(id_ex.id)] <= id_ex.instr;
        end
        if (ex_mem.valid) begin
            result_tab[slot(ex_mem.id)] <= ex_mem.result;
        end
    end

    ////////////////////
    // retire record

    assign wb_idx         = slot(mem_wb.id);
    assign retire_valid   = mem_wb.valid;
    assign retire_id      = mem_wb.id;
    assign retire_pc      = pc_tab[wb_idx];
    assign retire_instr   = instr_tab[wb_idx];
    // loads finish in memory, take the data read
    assign retire_result  = (mem_wb.op == OP_LD) ? mem_wb.result : result_tab[wb_idx];
    assign retire_flushed = mem_wb.flushed;
    assign retire_cycle   = cycle;

endmodule

// File: verilog/trace_cpu_top.sv
module trace_cpu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  logic                  imem_we,
    input  trace_cpu_pkg::addr_t  imem_addr,
    input  trace_cpu_pkg::word_t  imem_wdata,
    output logic                  retire_valid,
    output trace_cpu_pkg::id_t    retire_id,
    output trace_cpu_pkg::addr_t  retire_pc,
    output trace_cpu_pkg::word_t  retire_instr,
    output trace_cpu_pkg::word_t  retire_result,
    output logic                  retire_flushed,
    output trace_cpu_pkg::cycle_t retire_cycle,
    output logic                  halted
);
    import trace_cpu_pkg::*;

    logic  fetch_en;
    logic  stall;
    logic  flush;
    logic  branch_taken;
    addr_t branch_target;
    id_t   fetch_id;

    ////////////////////
    // pipeline registers

    stage_if if_id ();
    stage_if id_ex ();
    stage_if ex_mem ();
    stage_if mem_wb ();

    ////////////////////
    // control

    pipe_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .if_id        (if_id),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .branch_taken (branch_taken),
        .fetch_en     (fetch_en),
        .stall        (stall),
        .flush        (flush),
        .halted       (halted)
    );

    ////////////////////
    // stages

    fetch_stage u_fetch (
        .clk           (clk),
        .rst           (rst),
        .fetch_en      (fetch_en),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .fetch_id      (fetch_id),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .if_id         (if_id)
    );

    // writeback closes the loop into decode
    decode_stage u_decode (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .if_id  (if_id),
        .mem_wb (mem_wb),
        .id_ex  (id_ex)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst           (rst),
        .id_ex         (id_ex),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mem_stage u_mem (
        .clk    (clk),
        .rst    (rst),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    ////////////////////
    // trace

    trace_unit u_trace (
        .clk            (clk),
        .rst            (rst),
        .fetch_en       (fetch_en),
        .stall          (stall),
        .if_id          (if_id),
        .id_ex          (id_ex),
        .ex_mem         (ex_mem),
        .mem_wb         (mem_wb),
        .fetch_id       (fetch_id),
        .retire_valid   (retire_valid),
        .retire_id      (retire_id),
        .retire_pc      (retire_pc),
        .retire_instr   (retire_instr),
        .retire_result  (retire_result),
        .retire_flushed (retire_flushed),
        .retire_cycle   (retire_cycle)
    );

endmodule

// File: dv/trace_cpu_asserts.sv
module trace_cpu_asserts (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retire_valid,
    input  trace_cpu_pkg::id_t    retire_id,
    input  trace_cpu_pkg::cycle_t retire_cycle,
    input  logic                  halted,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  if_id_valid,
    input  logic                  if_id_flushed,
    input  trace_cpu_pkg::id_t    if_id_id
);
    timeunit 1ns;
    timeprecision 1ps;
    import trace_cpu_pkg::*;

    id_t    last_id;
    cycle_t last_cycle;
    logic   seen;
    // number of failed properties
    int     fail_count = 0;

    // last retire record since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            seen <= 1'b0;
        end else if (retire_valid) begin
            seen       <= 1'b1;
            last_id    <= retire_id;
            last_cycle <= retire_cycle;
        end
    end

    ////////////////////
    // retire stream

    // ids wrap at their width
    id_step: assert property (@(posedge clk) disable iff (rst)
        retire_valid && seen |-> retire_id == id_t'(last_id + id_t'(1)))
        else begin
            $error("retire_id did not advance by one");
            fail_count++;
        end

    cycle_up: assert property (@(posedge clk) disable iff (rst)
        retire_valid && seen |-> retire_cycle > last_cycle)
        else begin
            $error("retire_cycle did not increase");
            fail_count++;
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !retire_valid)
        else begin
            $error("retire record after halted");
            fail_count++;
        end

    ////////////////////
    // control

    // flush wins over stall and the next fetch arrives dead
    flush_wins: assert property (@(posedge clk) disable iff (rst)
        flush |=> if_id_valid && if_id_flushed)
        else begin
            $error("decode entry after a flush is not a flushed fetch");
            fail_count++;
        end

    // a stalled decode entry stays in place
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall |=> if_id_valid && !if_id_flushed && $stable(if_id_id))
        else begin
            $error("decode entry changed while stalled");
            fail_count++;
        end

endmodule

bind trace_cpu_top trace_cpu_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .retire_valid  (retire_valid),
    .retire_id     (retire_id),
    .retire_cycle  (retire_cycle),
    .halted        (halted),
    .stall         (stall),
    .flush         (flush),
    .if_id_valid   (if_id.valid),
    .if_id_flushed (if_id.flushed),
    .if_id_id      (if_id.id)
);

// File: dv/trace_cpu_tb.sv
`include "trace_cpu_config.svh"

module trace_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import trace_cpu_pkg::*;

    localparam int MEM_WORDS = 2**`TC_ADDR_W;

    // one expected retire record
    typedef struct packed {
        addr_t pc;
        word_t instr;
        word_t result;
        logic  flushed;
    } rec_t;

    logic   clk = 1'b0;
    logic   rst;
    logic   run;
    logic   imem_we;
    addr_t  imem_addr;
    word_t  imem_wdata;
    logic   retire_valid;
    id_t    retire_id;
    addr_t  retire_pc;
    word_t  retire_instr;
    word_t  retire_result;
    logic   retire_flushed;
    cycle_t retire_cycle;
    logic   halted;

    word_t  prog [MEM_WORDS];
    int     prog_len;
    rec_t   exp_q [$];
    int     rec_count;
    int     cycle_limit;
    int     run_cycles;
    cycle_t cycle_count;
    logic   failed = 1'b0;
    integer seed = 32'hc877_1c01;

    trace_cpu_top trace_cpu_top_inst (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .imem_we        (imem_we),
        .imem_addr      (imem_addr),
        .imem_wdata     (imem_wdata),
        .retire_valid   (retire_valid),
        .retire_id      (retire_id),
        .retire_pc      (retire_pc),
        .retire_instr   (retire_instr),
        .retire_result  (retire_result),
        .retire_flushed (retire_flushed),
        .retire_cycle   (retire_cycle),
        .halted         (halted)
    );

    // 8 ns period
    always #4 clk = ~clk;

    ////////////////////
    // failure reporting

    task automatic stop_on_failure();
        failed = 1'b1;
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_value(input string sig, input word_t expected, input word_t actual);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, sig, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%0t ns: %s", $time, what);
        stop_on_failure();
    endtask

    ////////////////////
    // encoding and program buffer

    // op, rd, rs, rt
    function automatic word_t rtype(input opcode_e op, input int rd, input int rs, input int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
    endfunction

    // op, rd, rs, signed 6 bit imm
    function automatic word_t itype(input opcode_e op, input int rd, input int rs, input int imm);
        return {op, 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    // unused words stay NOP
    task automatic clear_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = rtype(OP_NOP, 0, 0, 0);
        end
        prog_len = 0;
    endtask

    task automatic append_instr(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    ////////////////////
    // reference model

    // architectural run where every fetch becomes one record
    function automatic void build_expected();
        word_t   regs [8];
        word_t   dmem [MEM_WORDS];
        addr_t   pc;
        addr_t   next_pc;
        word_t   ins;
        word_t   imm;
        word_t   res;
        opcode_e op;
        logic    done;
        int      steps;
        exp_q.delete();
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            ins     = prog[pc];
            op      = opcode_e'(ins[15:12]);
            imm     = {{10{ins[5]}}, ins[5:0]};
            res     = '0;
            next_pc = pc + addr_t'(1);
            case (op)
                OP_ADD:  res = regs[ins[8:6]] + regs[ins[5:3]];
                OP_SUB:  res = regs[ins[8:6]] - regs[ins[5:3]];
                OP_ADDI: res = regs[ins[8:6]] + imm;
                OP_LD:   res = dmem[addr_t'(regs[ins[8:6]] + imm)];
                OP_ST: begin
                    // result shows the address
                    res = regs[ins[8:6]] + imm;
                    dmem[addr_t'(res)] = regs[ins[11:9]];
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            exp_q.push_back(rec_t'{pc: pc, instr: ins, result: res, flushed: 1'b0});
            // r0 is never written
            if (op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LD} && ins[11:9] != 3'd0) begin
                regs[ins[11:9]] = res;
            end
            // taken branch kills the next two fetches
            if (op == OP_BEQZ && regs[ins[8:6]] == '0) begin
                for (int k = 1; k <= 2; k++) begin
                    exp_q.push_back(rec_t'{pc: pc + addr_t'(k), instr: prog[pc + addr_t'(k)],
                                           result: '0, flushed: 1'b1});
                end
                next_pc = pc + addr_t'(1) + addr_t'(ins[5:0]);
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    ////////////////////
    // checker

    // clock edges since reset was released
    always @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + cycle_t'(1);
        end
    end

    task automatic check_record();
        rec_t exp;
        assert (exp_q.size() != 0)
            else report_problem("retire record appeared after the expected stream ended");
        assert (!halted) else report_problem("retire record appeared while halted was high");
        exp = exp_q.pop_front();
        assert (retire_id == id_t'(rec_count))
            else report_value("retire_id", word_t'(id_t'(rec_count)), word_t'(retire_id));
        assert (retire_pc == exp.pc)
            else report_value("retire_pc", word_t'(exp.pc), word_t'(retire_pc));
        assert (retire_instr == exp.instr)
            else report_value("retire_instr", exp.instr, retire_instr);
        assert (retire_flushed == exp.flushed)
            else report_value("retire_flushed", word_t'(exp.flushed), word_t'(retire_flushed));
        assert (retire_cycle == cycle_count)
            else report_value("retire_cycle", word_t'(cycle_count), word_t'(retire_cycle));
        // dead slots carry whatever decode happened to read
        if (!exp.flushed) begin
            assert (retire_result == exp.result)
                else report_value("retire_result", exp.result, retire_result);
        end
        rec_count++;
    endtask

    // retire outputs sampled mid cycle
    always @(negedge clk) begin
        if (trace_cpu_top_inst.u_asserts.fail_count != 0) begin
            report_problem("a bound assertion on the retire stream or control failed");
        end else if (!rst && retire_valid) begin
            check_record();
        end
    end

    ////////////////////
    // watchdog

    // cycle budget per program
    always @(posedge clk) begin
        if (!run) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
            if (run_cycles > cycle_limit) begin
                report_problem($sformatf("program did not halt within %0d cycles", cycle_limit));
            end
        end
    end

    ////////////////////
    // program runs

    // reset and load with run low, then run to halt
    task automatic run_program(input string name);
        build_expected();
        $display("program %s: %0d records expected", name, exp_q.size());
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        rec_count = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem_we    <= 1'b1;
            imem_addr  <= addr_t'(i);
            imem_wdata <= prog[i];
            @(posedge clk);
        end
        imem_we     <= 1'b0;
        cycle_limit = 6 * exp_q.size() + 60;
        run         <= 1'b1;
        while (!(halted && exp_q.size() == 0)) begin
            @(posedge clk);
        end
        // quiet window for late records
        repeat (20) @(posedge clk);
        run <= 1'b0;
    endtask

    // forward branches only that land at or before the HALT
    task automatic make_random_program();
        int n;
        int kind;
        int rd;
        int rs;
        int rt;
        int imm;
        int off_max;
        clear_program();
        n = 16 + ($unsigned($random(seed)) % 25);
        for (int i = 0; i < n - 1; i++) begin
            kind = $unsigned($random(seed)) % 8;
            rd   = $unsigned($random(seed)) % 8;
            rs   = $unsigned($random(seed)) % 8;
            rt   = $unsigned($random(seed)) % 8;
            imm  = $unsigned($random(seed)) % 64;
            case (kind)
                0: append_instr(rtype(OP_NOP, 0, 0, 0));
                1: append_instr(rtype(OP_ADD, rd, rs, rt));
                2: append_instr(rtype(OP_SUB, rd, rs, rt));
                3, 4: append_instr(itype(OP_ADDI, rd, rs, imm));
                5: append_instr(itype(OP_LD, rd, rs, imm));
                6: append_instr(itype(OP_ST, rd, rs, imm));
                default: begin
                    off_max = (n - 2 - i > 31) ? 31 : n - 2 - i;
                    append_instr(itype(OP_BEQZ, 0, rs,
                                       $unsigned($random(seed)) % (off_max + 1)));
                end
            endcase
        end
        append_instr(itype(OP_HALT, 0, 0, 0));
    endtask

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        cycle_limit = 0;

        // straight line alu
        clear_program();
        append_instr(itype(OP_ADDI, 1, 0, 5));
        append_instr(itype(OP_ADDI, 2, 0, 7));
        append_instr(itype(OP_ADDI, 3, 0, -2));
        append_instr(rtype(OP_NOP, 0, 0, 0));
        append_instr(rtype(OP_ADD, 4, 1, 2));
        append_instr(rtype(OP_SUB, 5, 2, 3));
        append_instr(itype(OP_ADDI, 6, 1, 31));
        append_instr(itype(OP_HALT, 0, 0, 0));
        run_program("straight");

        // back to back dependencies
        clear_program();
        append_instr(itype(OP_ADDI, 1, 0, 3));
        append_instr(rtype(OP_ADD, 2, 1, 1));
        append_instr(rtype(OP_SUB, 3, 2, 1));
        append_instr(itype(OP_ADDI, 3, 3, 10));
        append_instr(rtype(OP_ADD, 4, 3, 2));
        append_instr(rtype(OP_SUB, 1, 4, 1));
        append_instr(itype(OP_HALT, 0, 0, 0));
        run_program("dependent");

        // store then load at one address
        clear_program();
        append_instr(itype(OP_ADDI, 1, 0, 9));
        append_instr(itype(OP_ADDI, 2, 0, 20));
        append_instr(itype(OP_ST, 1, 2, 4));
        append_instr(itype(OP_LD, 3, 2, 4));
        append_instr(rtype(OP_ADD, 4, 3, 3));
        append_instr(itype(OP_ST, 4, 0, 24));
        append_instr(itype(OP_LD, 7, 0, 24));
        append_instr(itype(OP_HALT, 0, 0, 0));
        run_program("store_load");

        // taken branch to 5 then one not taken
        clear_program();
        append_instr(itype(OP_ADDI, 1, 0, 1));
        append_instr(itype(OP_BEQZ, 0, 0, 3));
        append_instr(itype(OP_ADDI, 2, 0, 11));
        append_instr(itype(OP_ADDI, 3, 0, 12));
        append_instr(itype(OP_ADDI, 4, 0, 13));
        append_instr(itype(OP_ADDI, 5, 0, 14));
        append_instr(itype(OP_BEQZ, 0, 1, 2));
        append_instr(rtype(OP_ADD, 6, 5, 1));
        append_instr(itype(OP_HALT, 0, 0, 0));
        run_program("branch");

        // HALTs in the flush shadow must not stop the run
        clear_program();
        append_instr(itype(OP_BEQZ, 0, 0, 2));
        append_instr(itype(OP_HALT, 0, 0, 0));
        append_instr(itype(OP_HALT, 0, 0, 0));
        append_instr(itype(OP_ADDI, 1, 0, 1));
        append_instr(itype(OP_HALT, 0, 0, 0));
        run_program("halt_shadow");

        for (int p = 0; p < 6; p++) begin
            make_random_program();
            run_program($sformatf("random_%0d", p));
        end

        if (!failed && trace_cpu_top_inst.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// File: trace_cpu.f
+incdir+common
common/trace_cpu_pkg.sv
common/stage_if.sv
pipeline/pipe_ctrl.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/mem_stage.sv
trace/trace_unit.sv
verilog/trace_cpu_top.sv
dv/trace_cpu_asserts.sv
dv/trace_cpu_tb.sv
